// File: verilog/nabp_config.svh
`ifndef NABP_CONFIG_SVH
`define NABP_CONFIG_SVH

// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// widths and row geometry
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// angle index width
`define kAngleLength 8
// detector sample address width
`define kSLength 5
// samples per projection row
`define kSCount 24
// raw host sample width
`define kDataLength 12
// signed filtered sample width
`define kFilteredDataLength 16
// number of rotating buffers
`define kRotate 3
// address out to filtered value back, in cycles
`define kFillLatency 2

`endif

// File: verilog/nabp_types_pkg.sv
`include "nabp_config.svh"

package nabp_types_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data widths shared by the datapath
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // projection angle index
    typedef logic [`kAngleLength-1:0] angle_t;

    // sample address along the detector row
    typedef logic [`kSLength-1:0] s_t;

    // raw sample as stored in host RAM, unsigned
    typedef logic [`kDataLength-1:0] raw_t;

    // high-pass output, can go negative
    typedef logic signed [`kFilteredDataLength-1:0] filtered_t;

endpackage

// File: verilog/nabp_ctrl_pkg.sv
package nabp_ctrl_pkg;

    // swap control states
    // fill runs alone first, then fill overlaps with processing
    typedef enum logic [2:0] {
        ready_s,
        fill_s,
        fill_and_work_s,
        fill_and_work_repeat_s,
        work_1_s,
        work_2_s
    } swap_state_t;

    // which buffer is filling, 0 to 2
    typedef logic [1:0] rotate_sel_t;

endpackage

// File: verilog/nabp_fir.sv
`timescale 1ns/100ps

module nabp_fir
    import nabp_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      fill_kick,
    input  raw_t      raw,
    output filtered_t filtered
);

    // kick seen one cycle late
    logic      kick_d;
    // x[n-1] and x[n-2]
    raw_t      hist_1;
    raw_t      hist_2;
    // kernel result before the output register
    filtered_t kernel;

    // host RAM answers one cycle after the address
    // so the clear must line up with the cycle before x[0]
    always_ff @(posedge clk)
    begin
        if (reset_n)
            kick_d <= 1'b0;
        else
            kick_d <= fill_kick;
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // history shift, zeroed at row start
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset_n || kick_d)
        begin
            // stale sample on this cycle is dropped
            hist_1 <= '0;
            hist_2 <= '0;
        end
        else
        begin
            hist_1 <= raw;
            hist_2 <= hist_1;
        end
    end

    // 2x[n] - x[n-1] - x[n-2]
    // raw is unsigned so the casts zero extend
    always_comb
    begin
        kernel = (filtered_t'(raw) <<< 1) - filtered_t'(hist_1) - filtered_t'(hist_2);
    end

    // registered output, one cycle after raw
    always_ff @(posedge clk)
    begin
        filtered <= kernel;
    end

endmodule

// File: verilog/nabp_filtered_ram_swappable.sv
`timescale 1ns/100ps
`include "nabp_config.svh"

module nabp_filtered_ram_swappable
    import nabp_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  logic      fill_kick,
    input  filtered_t hs_val,
    output s_t        hs_s_val,
    output logic      fill_done,
    input  s_t        pr_s_val,
    output filtered_t pr_val
);

    // last address of a row
    localparam s_t last_s   = s_t'(`kSCount - 1);
    // output tap of the alignment delay line
    localparam int last_tap = `kFillLatency - 1;

    // fill address counter
    s_t        s_cnt;
    logic      fill_active;
    // address and valid delay matching host RAM plus FIR
    s_t        addr_dly [`kFillLatency];
    logic      vld_dly  [`kFillLatency];
    // row buffer
    filtered_t mem [`kSCount];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fill side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // sweep 0 .. kSCount-1 starting the cycle after the kick
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            s_cnt       <= '0;
            fill_active <= 1'b0;
        end
        else if (fill_kick)
        begin
            s_cnt       <= '0;
            fill_active <= 1'b1;
        end
        else if (fill_active)
        begin
            // counter parks on the last address
            if (s_cnt == last_s)
                fill_active <= 1'b0;
            else
                s_cnt <= s_cnt + s_t'(1);
        end
    end

    assign hs_s_val = s_cnt;

    // valid flags of the delay line
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            for (int i = 0; i < `kFillLatency; i++)
                vld_dly[i] <= 1'b0;
        end
        else
        begin
            vld_dly[0] <= fill_active;
            for (int i = 1; i < `kFillLatency; i++)
                vld_dly[i] <= vld_dly[i-1];
        end
    end

    // addresses of the delay line
    always_ff @(posedge clk)
    begin
        addr_dly[0] <= s_cnt;
        for (int i = 1; i < `kFillLatency; i++)
            addr_dly[i] <= addr_dly[i-1];
    end

    // aligned write of the filtered sample
    always_ff @(posedge clk)
    begin
        if (vld_dly[last_tap])
            mem[addr_dly[last_tap]] <= hs_val;
    end

    // set on the last write, held until the next kick
    always_ff @(posedge clk)
    begin
        if (reset_n || fill_kick)
            fill_done <= 1'b0;
        else if (vld_dly[last_tap] && (addr_dly[last_tap] == last_s))
            fill_done <= 1'b1;
    end

    // processing read port, one cycle latency
    always_ff @(posedge clk)
    begin
        pr_val <= mem[pr_s_val];
    end

endmodule

// File: verilog/nabp_filtered_ram_swap_control.sv
`timescale 1ns/100ps
`include "nabp_config.svh"

module nabp_filtered_ram_swap_control
    import nabp_types_pkg::*;
    import nabp_ctrl_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    input  angle_t    hs_angle,
    input  logic      hs_has_next_angle,
    input  logic      hs_next_angle_ack,
    input  filtered_t hs_val,
    input  s_t        pr0_s_val,
    input  s_t        pr1_s_val,
    input  logic      pr_next_angle,
    input  logic      pr_done,
    output s_t        hs_s_val,
    output logic      hs_next_angle,
    output logic      fill_kick,
    output angle_t    pr0_angle,
    output angle_t    pr1_angle,
    output logic      pr0_angle_valid,
    output logic      pr1_angle_valid,
    output logic      pr_next_angle_ack,
    output filtered_t pr0_val,
    output filtered_t pr1_val
);

    swap_state_t state;
    swap_state_t next_state;
    rotate_sel_t rotate_sel;
    logic        rotate;
    logic        fill_done;
    // buffer roles for the current select
    rotate_sel_t fill_idx;
    rotate_sel_t pr0_idx;
    rotate_sel_t pr1_idx;
    rotate_sel_t kick_idx;
    // first angle stage, buffer still filling
    angle_t      angle_d;
    logic        angle_valid_d;
    // per-buffer wiring
    logic        sw_fill_kick [`kRotate];
    logic        sw_fill_done [`kRotate];
    s_t          sw_hs_s_val  [`kRotate];
    s_t          sw_pr_s_val  [`kRotate];
    filtered_t   sw_pr_val    [`kRotate];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // rotate decision, mealy
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb
    begin
        rotate        = 1'b0;
        hs_next_angle = 1'b0;
        case (state)
            // host starts the first fill unasked
            ready_s:
                rotate = hs_next_angle_ack;
            fill_s:
                if (fill_done)
                begin
                    hs_next_angle = hs_has_next_angle;
                    // no angle left means a drain rotate
                    rotate = hs_next_angle_ack || !hs_has_next_angle;
                end
            // both processors must be free as well
            fill_and_work_s, fill_and_work_repeat_s:
                if (fill_done && pr_next_angle)
                begin
                    hs_next_angle = hs_has_next_angle;
                    rotate = hs_next_angle_ack || !hs_has_next_angle;
                end
            // last angle moves from pr0 to pr1
            work_1_s:
                rotate = pr_next_angle;
            default:
                rotate = 1'b0;
        endcase
    end

    assign pr_next_angle_ack = rotate;
    assign fill_kick         = rotate;

    // acked rotate keeps filling, bare rotate drains
    always_comb
    begin
        next_state = state;
        case (state)
            ready_s:
                if (rotate)
                    next_state = fill_s;
            fill_s:
                if (rotate)
                    next_state = hs_next_angle_ack ? fill_and_work_s : work_1_s;
            fill_and_work_s, fill_and_work_repeat_s:
                if (rotate)
                    next_state = hs_next_angle_ack ? fill_and_work_repeat_s : work_1_s;
            work_1_s:
                if (rotate)
                    next_state = work_2_s;
            work_2_s:
                if (pr_done)
                    next_state = ready_s;
            default:
                next_state = ready_s;
        endcase
    end

    // state and modulo-3 rotation counter
    always_ff @(posedge clk)
    begin
        if (reset_n)
        begin
            state      <= ready_s;
            rotate_sel <= '0;
        end
        else
        begin
            state <= next_state;
            if (rotate)
                rotate_sel <= (rotate_sel == rotate_sel_t'(`kRotate - 1)) ? '0 :
                              rotate_sel + rotate_sel_t'(1);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // angle pipeline, two rotates deep
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk)
    begin
        if (reset_n || ((state == work_2_s) && pr_done))
        begin
            angle_valid_d   <= 1'b0;
            pr0_angle_valid <= 1'b0;
            pr1_angle_valid <= 1'b0;
        end
        else if (rotate)
        begin
            angle_valid_d   <= hs_next_angle_ack;
            pr0_angle_valid <= angle_valid_d;
            pr1_angle_valid <= pr0_angle_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (rotate)
        begin
            angle_d   <= hs_angle;
            pr0_angle <= angle_d;
            pr1_angle <= pr0_angle;
        end
    end

    // buffer roles per select
    // kick goes to the buffer that fills after the rotate
    always_comb
    begin
        case (rotate_sel)
            2'd1:
            begin
                fill_idx = 2'd2;
                pr0_idx  = 2'd0;
                pr1_idx  = 2'd1;
                kick_idx = 2'd1;
            end
            2'd2:
            begin
                fill_idx = 2'd1;
                pr0_idx  = 2'd2;
                pr1_idx  = 2'd0;
                kick_idx = 2'd0;
            end
            default:
            begin
                fill_idx = 2'd0;
                pr0_idx  = 2'd1;
                pr1_idx  = 2'd2;
                kick_idx = 2'd2;
            end
        endcase
    end

    // demux of kicks and read addresses
    always_comb
    begin
        for (int i = 0; i < `kRotate; i++)
        begin
            sw_fill_kick[i] = rotate && (rotate_sel_t'(i) == kick_idx);
            // filling buffer gets a parked address
            sw_pr_s_val[i]  = '0;
        end
        sw_pr_s_val[pr0_idx] = pr0_s_val;
        sw_pr_s_val[pr1_idx] = pr1_s_val;
    end

    // mux back to host and processors
    assign hs_s_val  = sw_hs_s_val[fill_idx];
    assign fill_done = sw_fill_done[fill_idx];
    assign pr0_val   = sw_pr_val[pr0_idx];
    assign pr1_val   = sw_pr_val[pr1_idx];

    // three rotating buffers, hs_val shared, only the kicked one writes
    for (genvar i = 0; i < `kRotate; i++)
    begin : g_sw
        nabp_filtered_ram_swappable sw_i
        (
            .clk       (clk),
            .reset_n   (reset_n),
            .fill_kick (sw_fill_kick[i]),
            .hs_val    (hs_val),
            .hs_s_val  (sw_hs_s_val[i]),
            .fill_done (sw_fill_done[i]),
            .pr_s_val  (sw_pr_s_val[i]),
            .pr_val    (sw_pr_val[i])
        );
    end

endmodule

// File: verilog/nabp_filtered_ram.sv
`timescale 1ns/100ps

module nabp_filtered_ram
    import nabp_types_pkg::*;
(
    input  logic      clk,
    input  logic      reset_n,
    // host handshake and read
    input  angle_t    hs_angle,
    input  logic      hs_has_next_angle,
    input  logic      hs_next_angle_ack,
    input  raw_t      hs_raw_val,
    output s_t        hs_s_val,
    output logic      hs_next_angle,
    // processing units
    input  s_t        pr0_s_val,
    input  s_t        pr1_s_val,
    input  logic      pr_next_angle,
    input  logic      pr_done,
    output angle_t    pr0_angle,
    output angle_t    pr1_angle,
    output logic      pr0_angle_valid,
    output logic      pr1_angle_valid,
    output logic      pr_next_angle_ack,
    output filtered_t pr0_val,
    output filtered_t pr1_val
);

    // FIR output toward the filling buffer
    filtered_t filtered;
    // row start, also clears the FIR history
    logic      fill_kick;

    // host row data through the high-pass filter
    nabp_fir fir_i
    (
        .clk       (clk),
        .reset_n   (reset_n),
        .fill_kick (fill_kick),
        .raw       (hs_raw_val),
        .filtered  (filtered)
    );

    // rotation, handshakes and buffers
    nabp_filtered_ram_swap_control swap_control_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_val            (filtered),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .pr_done           (pr_done),
        .hs_s_val          (hs_s_val),
        .hs_next_angle     (hs_next_angle),
        .fill_kick         (fill_kick),
        .pr0_angle         (pr0_angle),
        .pr1_angle         (pr1_angle),
        .pr0_angle_valid   (pr0_angle_valid),
        .pr1_angle_valid   (pr1_angle_valid),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

endmodule

// File: testbench/nabp_filtered_ram_tb.sv
`timescale 1ns/100ps
`include "nabp_config.svh"

module nabp_filtered_ram_tb
    import nabp_types_pkg::*;
    import nabp_ctrl_pkg::*;
();

    localparam int rows = 8;

    // one table row per host angle
    typedef struct {
        angle_t angle;
        int     stall;
        logic   last;
    } stim_row_t;

    // the last flag closes each of the two runs
    stim_row_t stim [rows] = '{
        '{8'd12,  0, 1'b0},
        '{8'd45,  3, 1'b0},
        '{8'd90,  0, 1'b0},
        '{8'd133, 5, 1'b0},
        '{8'd170, 2, 1'b1},
        '{8'd7,   4, 1'b0},
        '{8'd64,  0, 1'b0},
        '{8'd201, 1, 1'b1}
    };

    logic      clk;
    logic      reset_n;
    angle_t    hs_angle;
    logic      hs_has_next_angle;
    logic      hs_next_angle_ack;
    raw_t      hs_raw_val;
    s_t        hs_s_val;
    logic      hs_next_angle;
    s_t        pr0_s_val;
    s_t        pr1_s_val;
    logic      pr_next_angle;
    logic      pr_done;
    angle_t    pr0_angle;
    angle_t    pr1_angle;
    logic      pr0_angle_valid;
    logic      pr1_angle_valid;
    logic      pr_next_angle_ack;
    filtered_t pr0_val;
    filtered_t pr1_val;

    // host RAM with one row per table entry
    raw_t raw_mem [rows*`kSCount];
    int   host_idx;
    int   fill_row;
    logic run_go;
    int   errors;
    int   checks;
    int   pr1_count;
    // expected table row per pipeline stage or -1 when empty
    int   mirror_s0;
    int   mirror_pr0;
    int   mirror_pr1;

    nabp_filtered_ram nabp_filtered_ram_i
    (
        .clk               (clk),
        .reset_n           (reset_n),
        .hs_angle          (hs_angle),
        .hs_has_next_angle (hs_has_next_angle),
        .hs_next_angle_ack (hs_next_angle_ack),
        .hs_raw_val        (hs_raw_val),
        .hs_s_val          (hs_s_val),
        .hs_next_angle     (hs_next_angle),
        .pr0_s_val         (pr0_s_val),
        .pr1_s_val         (pr1_s_val),
        .pr_next_angle     (pr_next_angle),
        .pr_done           (pr_done),
        .pr0_angle         (pr0_angle),
        .pr1_angle         (pr1_angle),
        .pr0_angle_valid   (pr0_angle_valid),
        .pr1_angle_valid   (pr1_angle_valid),
        .pr_next_angle_ack (pr_next_angle_ack),
        .pr0_val           (pr0_val),
        .pr1_val           (pr1_val)
    );

    // 4 ns period
    always #2 clk = ~clk;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // expected values and compares
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // 2x[n] - x[n-1] - x[n-2] with zeros before the row
    function automatic filtered_t expected_filtered(int row, int n);
        int x0;
        int x1;
        int x2;
        x0 = int'(raw_mem[row*`kSCount + n]);
        x1 = (n >= 1) ? int'(raw_mem[row*`kSCount + n - 1]) : 0;
        x2 = (n >= 2) ? int'(raw_mem[row*`kSCount + n - 2]) : 0;
        return filtered_t'(2*x0 - x1 - x2);
    endfunction

    task automatic check_filtered(string name, filtered_t exp, filtered_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_angle(string name, angle_t exp, angle_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_flag(string name, logic exp, logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("error %s expected %b actual %b", name, exp, act);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // host model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // RAM answers one cycle after the address
    always @(posedge clk)
    begin
        if (hs_s_val < s_t'(`kSCount))
            hs_raw_val <= raw_mem[fill_row*`kSCount + int'(hs_s_val)];
    end

    // one-cycle ack per request and an unasked first ack per run
    initial
    begin : host_model
        logic rot;
        logic req;
        @(negedge reset_n);
        forever
        begin
            @(negedge clk);
            rot = pr_next_angle_ack;
            req = hs_next_angle;
            @(posedge clk);
            if (hs_next_angle_ack && rot)
            begin
                hs_next_angle_ack <= 1'b0;
                fill_row          <= host_idx;
                hs_has_next_angle <= !stim[host_idx].last;
                if (host_idx + 1 < rows)
                    hs_angle <= stim[host_idx+1].angle;
                host_idx = host_idx + 1;
                run_go   = 1'b0;
            end
            else if (!hs_next_angle_ack && (req || run_go))
                hs_next_angle_ack <= 1'b1;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // processor model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // address every cycle and data checked one cycle later
    task automatic read_rows(int r0, int r1, int stride);
        int count;
        int a;
        count = (`kSCount + stride - 1) / stride;
        for (int k = 0; k <= count; k++)
        begin
            @(posedge clk);
            if (k < count)
            begin
                pr0_s_val <= s_t'(k*stride);
                pr1_s_val <= s_t'(k*stride);
            end
            if (k > 0)
            begin
                a = (k - 1)*stride;
                @(negedge clk);
                if (r0 >= 0)
                    check_filtered($sformatf("pr0_val angle %0d s %0d", stim[r0].angle, a),
                                   expected_filtered(r0, a), pr0_val);
                if (r1 >= 0)
                    check_filtered($sformatf("pr1_val angle %0d s %0d", stim[r1].angle, a),
                                   expected_filtered(r1, a), pr1_val);
            end
        end
    endtask

    task automatic check_angles();
        check_flag("pr0_angle_valid", mirror_pr0 >= 0, pr0_angle_valid);
        check_flag("pr1_angle_valid", mirror_pr1 >= 0, pr1_angle_valid);
        if (mirror_pr0 >= 0)
            check_angle("pr0_angle", stim[mirror_pr0].angle, pr0_angle);
        if (mirror_pr1 >= 0)
            check_angle("pr1_angle", stim[mirror_pr1].angle, pr1_angle);
    endtask

    // control goes back to ready once the last angle drains
    task automatic finish_run();
        @(posedge clk);
        pr_done <= 1'b1;
        @(posedge clk);
        pr_done <= 1'b0;
        @(negedge clk);
        check_flag("pr0_angle_valid after done", 1'b0, pr0_angle_valid);
        check_flag("pr1_angle_valid after done", 1'b0, pr1_angle_valid);
        check_flag("hs_next_angle after done", 1'b0, hs_next_angle);
        check_flag("state ready after done", 1'b1,
                   nabp_filtered_ram_i.swap_control_i.state == ready_s);
    endtask

    task automatic process_run();
        int   stall;
        logic finished;
        finished   = 1'b0;
        mirror_s0  = -1;
        mirror_pr0 = -1;
        mirror_pr1 = -1;
        while (!finished)
        begin
            @(negedge clk);
            while (pr_next_angle_ack !== 1'b1)
                @(negedge clk);
            // stages advance one step per rotate
            mirror_pr1 = mirror_pr0;
            mirror_pr0 = mirror_s0;
            mirror_s0  = hs_next_angle_ack ? host_idx : -1;
            @(posedge clk);
            pr_next_angle <= 1'b0;
            @(negedge clk);
            check_angles();
            if (mirror_pr0 < 0 && mirror_pr1 < 0)
                continue;
            if (mirror_pr1 >= 0)
                pr1_count++;
            read_rows(mirror_pr0, mirror_pr1, 1);
            stall = (mirror_pr0 >= 0) ? stim[mirror_pr0].stall : stim[mirror_pr1].stall;
            if (stall > 0)
            begin
                // held processors block the host
                repeat (stall)
                begin
                    @(negedge clk);
                    check_flag("hs_next_angle during stall", 1'b0, hs_next_angle);
                end
                // sparse re-read of the unchanged buffers
                read_rows(mirror_pr0, mirror_pr1, 8);
            end
            if (mirror_pr0 < 0)
            begin
                finish_run();
                finished = 1'b1;
            end
            else
            begin
                @(posedge clk);
                pr_next_angle <= 1'b1;
            end
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // main sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial
    begin
        clk               = 1'b0;
        reset_n           = 1'b1;
        hs_angle          = stim[0].angle;
        hs_has_next_angle = 1'b0;
        hs_next_angle_ack = 1'b0;
        hs_raw_val        = '0;
        pr0_s_val         = '0;
        pr1_s_val         = '0;
        pr_next_angle     = 1'b0;
        pr_done           = 1'b0;
        host_idx          = 0;
        fill_row          = 0;
        run_go            = 1'b0;
        errors            = 0;
        checks            = 0;
        pr1_count         = 0;
        // first draw also seeds the generator
        raw_mem[0] = raw_t'($urandom(33));
        for (int i = 1; i < rows*`kSCount; i++)
            raw_mem[i] = raw_t'($urandom);

        repeat (5) @(posedge clk);
        reset_n <= 1'b0;

        // quiet until the first ack
        repeat (4)
        begin
            @(negedge clk);
            check_flag("hs_next_angle idle", 1'b0, hs_next_angle);
            check_flag("pr_next_angle_ack idle", 1'b0, pr_next_angle_ack);
            check_flag("pr0_angle_valid idle", 1'b0, pr0_angle_valid);
            check_flag("pr1_angle_valid idle", 1'b0, pr1_angle_valid);
            check_flag("hs_s_val idle", 1'b1, hs_s_val == '0);
        end

        while (host_idx < rows)
        begin
            run_go = 1'b1;
            process_run();
        end

        if (pr1_count != rows)
        begin
            errors++;
            $display("only %0d of %0d angles reached processor 1", pr1_count, rows);
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    // a row can cost up to two rotate periods
    initial
    begin : watchdog
        int max_stall;
        int limit;
        max_stall = 0;
        for (int i = 0; i < rows; i++)
            if (stim[i].stall > max_stall)
                max_stall = stim[i].stall;
        limit = 2*rows*(`kSCount + `kFillLatency + max_stall + 20) + 10;
        repeat (limit) @(posedge clk);
        $display("timeout after %0d cycles, the DUT stopped handshaking", limit);
        $display("Result: FAILED");
        $finish;
    end

endmodule

// File: vlog.f
+incdir+verilog
verilog/nabp_types_pkg.sv
verilog/nabp_ctrl_pkg.sv
verilog/nabp_fir.sv
verilog/nabp_filtered_ram_swappable.sv
verilog/nabp_filtered_ram_swap_control.sv
verilog/nabp_filtered_ram.sv
testbench/nabp_filtered_ram_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator and run, pass only when the pass line shows up
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f vlog.f --top-module nabp_filtered_ram_tb -o nabp_sim \
    && ./obj_dir/nabp_sim | tee /dev/stderr | grep -q "Result: PASSED" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }
